//--- wisc_cfg.svh
// Fixed sizes of the 16-bit WISC datapath, shared by the decode stage RTL
// and its testbench. Include this file wherever one of the widths is needed.
`ifndef WISC_CFG_SVH
`define WISC_CFG_SVH

// Data and instruction word width
`define DATA_W 16

// Register index width and register count
`define REG_IDX_W 3
`define NUM_REGS 8

// Link register written by jal and jalr
`define LINK_REG 7

// PC value shown on pcNew when no branch or jump is taken
`define RESET_PC 16'h0000

`endif

//--- wisc_pkg.sv
// Enumerated types of the WISC decode stage: major opcodes and the
// control word fields handed to the later pipeline stages.
package wisc_pkg;

    // Major opcode, instr[15:11]
    typedef enum logic [4:0] {
        opHalt  = 5'b00000,
        opNop   = 5'b00001,
        opJ     = 5'b00100,
        opJr    = 5'b00101,
        opJal   = 5'b00110,
        opJalr  = 5'b00111,
        opAddi  = 5'b01000,
        opSubi  = 5'b01001,
        opXori  = 5'b01010,
        opAndni = 5'b01011,
        opBeqz  = 5'b01100,
        opBnez  = 5'b01101,
        opBltz  = 5'b01110,
        opBgez  = 5'b01111,
        opSt    = 5'b10000,
        opLd    = 5'b10001,
        opSlbi  = 5'b10010,
        opStu   = 5'b10011,
        opLbi   = 5'b11000,
        opRType = 5'b11011,
        opSeq   = 5'b11100,
        opSlt   = 5'b11101,
        opSle   = 5'b11110,
        opSco   = 5'b11111
    } opcodeT;

    // Operation performed by the execute stage ALU
    typedef enum logic [3:0] {
        aluAdd, aluSub, aluXor, aluAndn,
        aluRol, aluSll, aluRor, aluSrl,
        aluPass, aluSlbi
    } aluOpT;

    // Condition tested on the first operand
    typedef enum logic [2:0] {
        condNone, condEqz, condNez, condLtz, condGez
    } branchCondT;

    // Jump kind; the two link kinds also write R7
    typedef enum logic [2:0] {
        jNone, jImm, jReg, jalImm, jalReg
    } jumpKindT;

endpackage

//--- regFileBypass.sv
// Eight-entry register file, two combinational read ports and one write port.
// A write in progress is passed straight through to a read of the same register.
`include "wisc_cfg.svh"

module regFileBypass (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic [`REG_IDX_W-1:0] rdSel1,
    input  logic [`REG_IDX_W-1:0] rdSel2,
    input  logic [`REG_IDX_W-1:0] wrSel,
    input  logic [`DATA_W-1:0]    wrData,
    input  logic                  wrEn,
    output logic [`DATA_W-1:0]    rdData1,
    output logic [`DATA_W-1:0]    rdData2
);

    logic [`DATA_W-1:0] regs [`NUM_REGS];
    logic               hit1;
    logic               hit2;

    // R0 is an ordinary register here
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrSel] <= wrData;
        end
    end

    // Write-to-read bypass
    assign hit1 = wrEn && (wrSel == rdSel1);
    assign hit2 = wrEn && (wrSel == rdSel2);

    assign rdData1 = hit1 ? wrData : regs[rdSel1];
    assign rdData2 = hit2 ? wrData : regs[rdSel2];

endmodule

//--- immExtend.sv
// Immediate extension: picks the 5, 8 or 11 bit field of the instruction
// by opcode and sign- or zero-extends it to the data width.
`include "wisc_cfg.svh"

module immExtend (
    input  logic [`DATA_W-1:0] instr,
    output logic [`DATA_W-1:0] immVal
);

    import wisc_pkg::*;

    opcodeT opcode;

    assign opcode = opcodeT'(instr[15:11]);

    always_comb begin
        case (opcode)
            // I-format 1, signed
            opAddi, opSubi, opLd, opSt, opStu:
                immVal = {{(`DATA_W-5){instr[4]}}, instr[4:0]};
            // Logical immediates are unsigned
            opXori, opAndni:
                immVal = {{(`DATA_W-5){1'b0}}, instr[4:0]};
            opSlbi:
                immVal = {{(`DATA_W-8){1'b0}}, instr[7:0]};
            opBeqz, opBnez, opBltz, opBgez, opLbi, opJr, opJalr:
                immVal = {{(`DATA_W-8){instr[7]}}, instr[7:0]};
            // J-format displacement
            opJ, opJal:
                immVal = {{(`DATA_W-11){instr[10]}}, instr[10:0]};
            default:
                immVal = '0;
        endcase
    end

endmodule

//--- branchUnit.sv
// Branch condition check on the forwarded first operand.
`include "wisc_cfg.svh"

module branchUnit (
    input  logic [`DATA_W-1:0]    opnd,
    input  wisc_pkg::branchCondT  cond,
    output logic                  taken
);

    import wisc_pkg::*;

    logic isZero;
    logic isNeg;

    assign isZero = (opnd == '0);
    assign isNeg  = opnd[`DATA_W-1];

    always_comb begin
        case (cond)
            condEqz: taken = isZero;
            condNez: taken = !isZero;
            condLtz: taken = isNeg;
            condGez: taken = !isNeg;
            default: taken = 1'b0;
        endcase
    end

endmodule

//--- controlUnit.sv
// Combinational instruction decoder. Produces the control word for the
// execute, memory and write-back stages from the major opcode.
`include "wisc_cfg.svh"

module controlUnit (
    input  logic [`DATA_W-1:0]   instr,
    output wisc_pkg::aluOpT      aluOp,
    output wisc_pkg::branchCondT branchCond,
    output wisc_pkg::jumpKindT   jumpKind,
    output logic                 regWrite,
    output logic                 aluSrc,
    output logic                 memWrite,
    output logic                 memRead,
    output logic                 memToReg,
    output logic                 stu,
    output logic                 lbi,
    output logic                 slbi
);

    import wisc_pkg::*;

    opcodeT opcode;
    aluOpT  rFunc;

    assign opcode = opcodeT'(instr[15:11]);

    // R-format function field
    always_comb begin
        case (instr[1:0])
            2'b00:   rFunc = aluAdd;
            2'b01:   rFunc = aluSub;
            2'b10:   rFunc = aluXor;
            default: rFunc = aluAndn;
        endcase
    end

    always_comb begin
        // Inactive word, also used for halt and unknown opcodes
        aluOp      = aluPass;
        branchCond = condNone;
        jumpKind   = jNone;
        regWrite   = 1'b0;
        aluSrc     = 1'b0;
        memWrite   = 1'b0;
        memRead    = 1'b0;
        memToReg   = 1'b0;
        stu        = 1'b0;
        lbi        = 1'b0;
        slbi       = 1'b0;
        case (opcode)
            opAddi, opSubi, opXori, opAndni: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                case (opcode)
                    opAddi:  aluOp = aluAdd;
                    opSubi:  aluOp = aluSub;
                    opXori:  aluOp = aluXor;
                    default: aluOp = aluAndn;
                endcase
            end
            opSlbi: begin
                aluOp    = aluSlbi;
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                slbi     = 1'b1;
            end
            opLbi: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                lbi      = 1'b1;
            end
            opSt: begin
                aluOp    = aluAdd;
                aluSrc   = 1'b1;
                memWrite = 1'b1;
            end
            opLd: begin
                aluOp    = aluAdd;
                aluSrc   = 1'b1;
                memRead  = 1'b1;
                memToReg = 1'b1;
                regWrite = 1'b1;
            end
            // Store with base update writes Rs back
            opStu: begin
                aluOp    = aluAdd;
                aluSrc   = 1'b1;
                memWrite = 1'b1;
                regWrite = 1'b1;
                stu      = 1'b1;
            end
            opBeqz: branchCond = condEqz;
            opBnez: branchCond = condNez;
            opBltz: branchCond = condLtz;
            opBgez: branchCond = condGez;
            opJ:    jumpKind = jImm;
            opJr:   jumpKind = jReg;
            opJal: begin
                jumpKind = jalImm;
                regWrite = 1'b1;
            end
            opJalr: begin
                jumpKind = jalReg;
                regWrite = 1'b1;
            end
            opRType: begin
                aluOp    = rFunc;
                regWrite = 1'b1;
            end
            // Compares use subtraction, carry-out uses the adder
            opSeq, opSlt, opSle: begin
                aluOp    = aluSub;
                regWrite = 1'b1;
            end
            opSco: begin
                aluOp    = aluAdd;
                regWrite = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

//--- decode.sv
// Decode stage datapath. Reads the register file, extends the immediate,
// forwards Rs from EX and MEM, resolves branches and jumps, and drives
// the next PC back to fetch in the same cycle.
`include "wisc_cfg.svh"

module decode (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic [`DATA_W-1:0]    instr,
    input  logic [`DATA_W-1:0]    pcInc,
    input  logic                  wbEn,
    input  logic [`REG_IDX_W-1:0] wbRd,
    input  logic [`DATA_W-1:0]    wbData,
    input  logic                  exFwdEn,
    input  logic [`REG_IDX_W-1:0] exRd,
    input  logic [`DATA_W-1:0]    exData,
    input  logic                  exLink,
    input  logic [`DATA_W-1:0]    exPcInc,
    input  logic                  memFwdEn,
    input  logic [`REG_IDX_W-1:0] memRd,
    input  logic [`DATA_W-1:0]    memData,
    input  logic                  memLink,
    input  logic [`DATA_W-1:0]    memPcInc,
    output logic [`DATA_W-1:0]    read1Data,
    output logic [`DATA_W-1:0]    read2Data,
    output logic [`DATA_W-1:0]    immVal,
    output logic [`DATA_W-1:0]    pcNew,
    output logic [`REG_IDX_W-1:0] rdOut,
    output wisc_pkg::aluOpT       aluOp,
    output wisc_pkg::branchCondT  branchCond,
    output wisc_pkg::jumpKindT    jumpKind,
    output logic                  regWrite,
    output logic                  aluSrc,
    output logic                  memWrite,
    output logic                  memRead,
    output logic                  memToReg,
    output logic                  stu,
    output logic                  lbi,
    output logic                  slbi,
    output logic                  pcSrc,
    output logic                  flush
);

    import wisc_pkg::*;

    localparam logic [`REG_IDX_W-1:0] linkReg = `LINK_REG;

    logic [`REG_IDX_W-1:0] rs;
    logic [`REG_IDX_W-1:0] rt;
    logic                  exHit;
    logic                  memHit;
    logic [`DATA_W-1:0]    exVal;
    logic [`DATA_W-1:0]    memVal;
    logic [`DATA_W-1:0]    fwdRs;
    logic [`DATA_W-1:0]    targetBase;
    logic [`DATA_W-1:0]    target;
    logic                  taken;
    logic                  isLink;
    logic                  isRegJump;

    assign rs = instr[10:8];
    assign rt = instr[7:5];

    regFileBypass regs0 (
        .clk     (clk),
        .arstN   (arstN),
        .rdSel1  (rs),
        .rdSel2  (rt),
        .wrSel   (wbRd),
        .wrData  (wbData),
        .wrEn    (wbEn),
        .rdData1 (read1Data),
        .rdData2 (read2Data)
    );

    immExtend imm0 (
        .instr  (instr),
        .immVal (immVal)
    );

    controlUnit ctrl0 (
        .instr      (instr),
        .aluOp      (aluOp),
        .branchCond (branchCond),
        .jumpKind   (jumpKind),
        .regWrite   (regWrite),
        .aluSrc     (aluSrc),
        .memWrite   (memWrite),
        .memRead    (memRead),
        .memToReg   (memToReg),
        .stu        (stu),
        .lbi        (lbi),
        .slbi       (slbi)
    );

    // Forwarding of Rs, EX has priority over MEM
    assign exHit  = exFwdEn && (exRd == rs);
    assign memHit = memFwdEn && (memRd == rs);

    // A linking stage carries its return address, not its ALU result
    assign exVal  = (exLink && exRd == linkReg) ? exPcInc : exData;
    assign memVal = (memLink && memRd == linkReg) ? memPcInc : memData;

    assign fwdRs = exHit  ? exVal  :
                   memHit ? memVal :
                   read1Data;

    branchUnit br0 (
        .opnd  (fwdRs),
        .cond  (branchCond),
        .taken (taken)
    );

    // Target adder
    assign isRegJump  = (jumpKind == jReg) || (jumpKind == jalReg);
    assign targetBase = isRegJump ? fwdRs : pcInc;
    assign target     = targetBase + immVal;

    assign pcSrc = taken || (jumpKind != jNone);
    assign flush = pcSrc;
    assign pcNew = pcSrc ? target : '0;

    // Destination register
    assign isLink = (jumpKind == jalImm) || (jumpKind == jalReg);

    always_comb begin
        if (stu || lbi || slbi) begin
            rdOut = rs;
        end else if (isLink) begin
            rdOut = linkReg;
        end else if (instr[15:14] == 2'b11) begin
            rdOut = instr[4:2];
        end else begin
            rdOut = rt;
        end
    end

endmodule

//--- decodeTop.sv
// Top of the decode subsystem: the decode stage and its ID/EX pipeline
// register. PC select outputs are combinational, everything else is one
// cycle behind the instruction.
`include "wisc_cfg.svh"

module decodeTop (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic [`DATA_W-1:0]    instr,
    input  logic [`DATA_W-1:0]    pcInc,
    input  logic                  wbEn,
    input  logic [`REG_IDX_W-1:0] wbRd,
    input  logic [`DATA_W-1:0]    wbData,
    input  logic                  exFwdEn,
    input  logic [`REG_IDX_W-1:0] exRd,
    input  logic [`DATA_W-1:0]    exData,
    input  logic                  exLink,
    input  logic [`DATA_W-1:0]    exPcInc,
    input  logic                  memFwdEn,
    input  logic [`REG_IDX_W-1:0] memRd,
    input  logic [`DATA_W-1:0]    memData,
    input  logic                  memLink,
    input  logic [`DATA_W-1:0]    memPcInc,
    output logic                  pcSrc,
    output logic [`DATA_W-1:0]    pcNew,
    output logic                  flush,
    output wisc_pkg::aluOpT       idAluOp,
    output logic                  idRegWrite,
    output logic                  idAluSrc,
    output logic                  idMemWrite,
    output logic                  idMemRead,
    output logic                  idMemToReg,
    output logic [`DATA_W-1:0]    idRead1Data,
    output logic [`DATA_W-1:0]    idRead2Data,
    output logic [`DATA_W-1:0]    idImmVal,
    output logic [`REG_IDX_W-1:0] idRd,
    output logic [`DATA_W-1:0]    idPcInc
);

    import wisc_pkg::*;

    aluOpT                 aluOp;
    logic                  regWrite;
    logic                  aluSrc;
    logic                  memWrite;
    logic                  memRead;
    logic                  memToReg;
    logic [`DATA_W-1:0]    read1Data;
    logic [`DATA_W-1:0]    read2Data;
    logic [`DATA_W-1:0]    immVal;
    logic [`REG_IDX_W-1:0] rdOut;

    decode dec0 (
        .clk        (clk),
        .arstN      (arstN),
        .instr      (instr),
        .pcInc      (pcInc),
        .wbEn       (wbEn),
        .wbRd       (wbRd),
        .wbData     (wbData),
        .exFwdEn    (exFwdEn),
        .exRd       (exRd),
        .exData     (exData),
        .exLink     (exLink),
        .exPcInc    (exPcInc),
        .memFwdEn   (memFwdEn),
        .memRd      (memRd),
        .memData    (memData),
        .memLink    (memLink),
        .memPcInc   (memPcInc),
        .read1Data  (read1Data),
        .read2Data  (read2Data),
        .immVal     (immVal),
        .pcNew      (pcNew),
        .rdOut      (rdOut),
        .aluOp      (aluOp),
        .branchCond (),
        .jumpKind   (),
        .regWrite   (regWrite),
        .aluSrc     (aluSrc),
        .memWrite   (memWrite),
        .memRead    (memRead),
        .memToReg   (memToReg),
        .stu        (),
        .lbi        (),
        .slbi       (),
        .pcSrc      (pcSrc),
        .flush      (flush)
    );

    // ID/EX register; a flushing instruction is still captured
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            idAluOp     <= aluPass;
            idRegWrite  <= 1'b0;
            idAluSrc    <= 1'b0;
            idMemWrite  <= 1'b0;
            idMemRead   <= 1'b0;
            idMemToReg  <= 1'b0;
            idRead1Data <= '0;
            idRead2Data <= '0;
            idImmVal    <= '0;
            idRd        <= '0;
            idPcInc     <= '0;
        end else begin
            idAluOp     <= aluOp;
            idRegWrite  <= regWrite;
            idAluSrc    <= aluSrc;
            idMemWrite  <= memWrite;
            idMemRead   <= memRead;
            idMemToReg  <= memToReg;
            idRead1Data <= read1Data;
            idRead2Data <= read2Data;
            idImmVal    <= immVal;
            idRd        <= rdOut;
            idPcInc     <= pcInc;
        end
    end

endmodule

//--- decode_assertions.sv
// Checker bound into decodeTop. Keeps a shadow register file, works out the
// expected decode results from the instruction set rules, and asserts on them.
`include "wisc_cfg.svh"

module decode_assertions (
    input logic                  clk,
    input logic                  arstN,
    input logic [`DATA_W-1:0]    instr,
    input logic [`DATA_W-1:0]    pcInc,
    input logic                  wbEn,
    input logic [`REG_IDX_W-1:0] wbRd,
    input logic [`DATA_W-1:0]    wbData,
    input logic                  exFwdEn,
    input logic [`REG_IDX_W-1:0] exRd,
    input logic [`DATA_W-1:0]    exData,
    input logic                  exLink,
    input logic [`DATA_W-1:0]    exPcInc,
    input logic                  memFwdEn,
    input logic [`REG_IDX_W-1:0] memRd,
    input logic [`DATA_W-1:0]    memData,
    input logic                  memLink,
    input logic [`DATA_W-1:0]    memPcInc,
    input logic                  pcSrc,
    input logic [`DATA_W-1:0]    pcNew,
    input logic                  flush,
    input wisc_pkg::aluOpT       idAluOp,
    input logic                  idRegWrite,
    input logic                  idAluSrc,
    input logic                  idMemWrite,
    input logic                  idMemRead,
    input logic                  idMemToReg,
    input logic [`DATA_W-1:0]    idRead1Data,
    input logic [`DATA_W-1:0]    idRead2Data,
    input logic [`DATA_W-1:0]    idImmVal,
    input logic [`REG_IDX_W-1:0] idRd,
    input logic [`DATA_W-1:0]    idPcInc
);

    import wisc_pkg::*;

    // Read by the testbench after each test
    int failCount = 0;

    logic [`DATA_W-1:0]    shadow [`NUM_REGS];
    opcodeT                op;
    logic [`REG_IDX_W-1:0] rs;
    logic [`REG_IDX_W-1:0] rt;
    logic [`DATA_W-1:0]    read1Exp;
    logic [`DATA_W-1:0]    read2Exp;
    logic [`DATA_W-1:0]    fwdExp;
    logic [`DATA_W-1:0]    baseExp;
    logic [`DATA_W-1:0]    pcNewExp;
    logic                  takeExp;
    logic [8:0]            idCtrl;
    logic [8:0]            ctrlQ;
    logic [`DATA_W-1:0]    read1Q;
    logic [`DATA_W-1:0]    read2Q;
    logic [`DATA_W-1:0]    immQ;
    logic [`DATA_W-1:0]    pcIncQ;
    logic [`REG_IDX_W-1:0] rdQ;

    // Control word as {aluOp, regWrite, aluSrc, memWrite, memRead, memToReg}
    function automatic logic [8:0] ctrlWord(opcodeT opc, logic [1:0] fn);
        aluOpT rAlu;
        case (fn)
            2'd0:    rAlu = aluAdd;
            2'd1:    rAlu = aluSub;
            2'd2:    rAlu = aluXor;
            default: rAlu = aluAndn;
        endcase
        case (opc)
            opAddi:              return {aluAdd, 5'b11000};
            opSubi:              return {aluSub, 5'b11000};
            opXori:              return {aluXor, 5'b11000};
            opAndni:             return {aluAndn, 5'b11000};
            opSlbi:              return {aluSlbi, 5'b11000};
            opLbi:               return {aluPass, 5'b11000};
            opSt:                return {aluAdd, 5'b01100};
            opLd:                return {aluAdd, 5'b11011};
            opStu:               return {aluAdd, 5'b11100};
            opJal, opJalr:       return {aluPass, 5'b10000};
            opRType:             return {rAlu, 5'b10000};
            opSeq, opSlt, opSle: return {aluSub, 5'b10000};
            opSco:               return {aluAdd, 5'b10000};
            default:             return {aluPass, 5'b00000};
        endcase
    endfunction

    function automatic logic [`DATA_W-1:0] immOf(logic [`DATA_W-1:0] ins);
        case (opcodeT'(ins[15:11]))
            opAddi, opSubi, opLd, opSt, opStu:
                return `DATA_W'($signed(ins[4:0]));
            opXori, opAndni:
                return `DATA_W'(ins[4:0]);
            opSlbi:
                return `DATA_W'(ins[7:0]);
            opBeqz, opBnez, opBltz, opBgez, opLbi, opJr, opJalr:
                return `DATA_W'($signed(ins[7:0]));
            opJ, opJal:
                return `DATA_W'($signed(ins[10:0]));
            default:
                return '0;
        endcase
    endfunction

    function automatic logic [`REG_IDX_W-1:0] rdOf(logic [`DATA_W-1:0] ins);
        case (opcodeT'(ins[15:11]))
            opStu, opLbi, opSlbi:                 return ins[10:8];
            opJal, opJalr:                        return `REG_IDX_W'(`LINK_REG);
            opRType, opSeq, opSlt, opSle, opSco:  return ins[4:2];
            default:                              return ins[7:5];
        endcase
    endfunction

    always_comb begin
        op = opcodeT'(instr[15:11]);
        rs = instr[10:8];
        rt = instr[7:5];
        read1Exp = (wbEn && wbRd == rs) ? wbData : shadow[rs];
        read2Exp = (wbEn && wbRd == rt) ? wbData : shadow[rt];
        // EX before MEM before the register file
        if (exFwdEn && exRd == rs) begin
            fwdExp = (exLink && exRd == `LINK_REG) ? exPcInc : exData;
        end else if (memFwdEn && memRd == rs) begin
            fwdExp = (memLink && memRd == `LINK_REG) ? memPcInc : memData;
        end else begin
            fwdExp = read1Exp;
        end
        case (op)
            opBeqz:                   takeExp = (fwdExp == '0);
            opBnez:                   takeExp = (fwdExp != '0);
            opBltz:                   takeExp = fwdExp[`DATA_W-1];
            opBgez:                   takeExp = !fwdExp[`DATA_W-1];
            opJ, opJal, opJr, opJalr: takeExp = 1'b1;
            default:                  takeExp = 1'b0;
        endcase
        baseExp  = (op == opJr || op == opJalr) ? fwdExp : pcInc;
        pcNewExp = takeExp ? baseExp + immOf(instr) : `RESET_PC;
    end

    // Shadow registers and the expected ID/EX contents
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                shadow[i] <= '0;
            end
            ctrlQ  <= {aluPass, 5'b00000};
            read1Q <= '0;
            read2Q <= '0;
            immQ   <= '0;
            pcIncQ <= '0;
            rdQ    <= '0;
        end else begin
            if (wbEn) begin
                shadow[wbRd] <= wbData;
            end
            ctrlQ  <= ctrlWord(op, instr[1:0]);
            read1Q <= read1Exp;
            read2Q <= read2Exp;
            immQ   <= immOf(instr);
            pcIncQ <= pcInc;
            rdQ    <= rdOf(instr);
        end
    end

    assign idCtrl = {idAluOp, idRegWrite, idAluSrc, idMemWrite, idMemRead, idMemToReg};

    resetA: assert property (@(posedge clk) $rose(arstN) |->
        idCtrl == {aluPass, 5'b00000} && idRead1Data == '0 && idRead2Data == '0 &&
        idImmVal == '0 && idRd == '0 && idPcInc == '0)
        else begin
            failCount++;
            $error("ID/EX outputs were not inactive and zero after reset");
        end

    ctrlA: assert property (@(posedge clk) disable iff (!arstN) idCtrl == ctrlQ)
        else begin
            failCount++;
            $error("ERROR idCtrl 0x%h expected 0x%h", $sampled(idCtrl), $sampled(ctrlQ));
        end

    read1A: assert property (@(posedge clk) disable iff (!arstN) idRead1Data == read1Q)
        else begin
            failCount++;
            $error("ERROR idRead1Data 0x%h expected 0x%h",
                $sampled(idRead1Data), $sampled(read1Q));
        end

    read2A: assert property (@(posedge clk) disable iff (!arstN) idRead2Data == read2Q)
        else begin
            failCount++;
            $error("ERROR idRead2Data 0x%h expected 0x%h",
                $sampled(idRead2Data), $sampled(read2Q));
        end

    immA: assert property (@(posedge clk) disable iff (!arstN) idImmVal == immQ)
        else begin
            failCount++;
            $error("ERROR idImmVal 0x%h expected 0x%h", $sampled(idImmVal), $sampled(immQ));
        end

    rdA: assert property (@(posedge clk) disable iff (!arstN)
        idRd == rdQ && idPcInc == pcIncQ)
        else begin
            failCount++;
            $error("ERROR idRd/idPcInc 0x%h/0x%h expected 0x%h/0x%h",
                $sampled(idRd), $sampled(idPcInc), $sampled(rdQ), $sampled(pcIncQ));
        end

    // PC select is combinational and is compared in the same cycle
    pcSrcA: assert property (@(posedge clk) disable iff (!arstN)
        pcSrc == takeExp && flush == takeExp)
        else begin
            failCount++;
            $error("ERROR pcSrc/flush 0x%h/0x%h expected 0x%h",
                $sampled(pcSrc), $sampled(flush), $sampled(takeExp));
        end

    pcNewA: assert property (@(posedge clk) disable iff (!arstN) pcNew == pcNewExp)
        else begin
            failCount++;
            $error("ERROR pcNew 0x%h expected 0x%h", $sampled(pcNew), $sampled(pcNewExp));
        end

endmodule

bind decodeTop decode_assertions chk0 (.*);

//--- tb_decode.sv
// Testbench for the WISC decode subsystem. Drives instruction, write-back
// and forwarding stimulus into decodeTop; the bound checker compares results.
`include "wisc_cfg.svh"

module tb_decode;

    import wisc_pkg::*;

    localparam int ClkPeriod   = 40;
    localparam int ResetCycles = 2;
    // Cycles per test, two drain cycles included
    localparam int RegCycles    = 34;
    localparam int CtrlCycles   = 44;
    localparam int BranchCycles = 14;
    localparam int FwdCycles    = 5;
    localparam int LinkCycles   = 5;
    localparam int MarginCycles = 20;
    localparam int TotalCycles  = ResetCycles + 2 + RegCycles + CtrlCycles +
                                  BranchCycles + FwdCycles + LinkCycles + MarginCycles;

    logic                  clk;
    logic                  arstN;
    logic [`DATA_W-1:0]    instr;
    logic [`DATA_W-1:0]    pcInc;
    logic                  wbEn;
    logic [`REG_IDX_W-1:0] wbRd;
    logic [`DATA_W-1:0]    wbData;
    logic                  exFwdEn;
    logic [`REG_IDX_W-1:0] exRd;
    logic [`DATA_W-1:0]    exData;
    logic                  exLink;
    logic [`DATA_W-1:0]    exPcInc;
    logic                  memFwdEn;
    logic [`REG_IDX_W-1:0] memRd;
    logic [`DATA_W-1:0]    memData;
    logic                  memLink;
    logic [`DATA_W-1:0]    memPcInc;
    logic                  pcSrc;
    logic [`DATA_W-1:0]    pcNew;
    logic                  flush;
    aluOpT                 idAluOp;
    logic                  idRegWrite;
    logic                  idAluSrc;
    logic                  idMemWrite;
    logic                  idMemRead;
    logic                  idMemToReg;
    logic [`DATA_W-1:0]    idRead1Data;
    logic [`DATA_W-1:0]    idRead2Data;
    logic [`DATA_W-1:0]    idImmVal;
    logic [`REG_IDX_W-1:0] idRd;
    logic [`DATA_W-1:0]    idPcInc;

    logic [31:0]           rng;
    logic [`REG_IDX_W-1:0] rs;
    int                    failsBefore;
    int                    testsRun;
    int                    testsFailed;

    opcodeT opList [21] = '{opNop, opHalt, opAddi, opSubi, opXori, opAndni, opSlbi,
                            opLbi, opSt, opLd, opStu, opJ, opJal, opJr, opJalr,
                            opRType, opSeq, opSlt, opSle, opSco, opBeqz};
    opcodeT brList [4]  = '{opBeqz, opBnez, opBltz, opBgez};

    decodeTop dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    initial begin
        #(TotalCycles * ClkPeriod);
        $display("Watchdog expired before all tests finished");
        $display("TEST FAIL");
        $finish;
    end

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // No write-back and no forwarding for the coming cycle
    task automatic quiet();
        wbEn     <= 1'b0;
        exFwdEn  <= 1'b0;
        exLink   <= 1'b0;
        memFwdEn <= 1'b0;
        memLink  <= 1'b0;
    endtask

    // Last instruction needs two edges to reach the ID/EX checks
    task automatic reportTest(string name);
        int fails;
        repeat (2) @(posedge clk);
        #1;
        fails = dut0.chk0.failCount - failsBefore;
        failsBefore = dut0.chk0.failCount;
        testsRun++;
        if (fails != 0) begin
            testsFailed++;
        end
        $display("%-16s %0d assertion failures", name, fails);
    endtask

    initial begin
        rng = 32'd31290;
        failsBefore = 0;
        testsRun = 0;
        testsFailed = 0;
        arstN = 1'b0;
        instr = '0;
        pcInc = '0;
        wbEn = 1'b0;
        wbRd = '0;
        wbData = '0;
        exFwdEn = 1'b0;
        exRd = '0;
        exData = '0;
        exLink = 1'b0;
        exPcInc = '0;
        memFwdEn = 1'b0;
        memRd = '0;
        memData = '0;
        memLink = 1'b0;
        memPcInc = '0;

        // Reset values are checked on the first edge after release
        repeat (ResetCycles) @(posedge clk);
        arstN <= 1'b1;
        reportTest("reset");

        for (int i = 0; i < RegCycles - 2; i++) begin
            @(posedge clk);
            rng = xorshift(rng);
            wbEn   <= rng[0] | rng[1];
            wbRd   <= rng[4:2];
            wbData <= rng[31:16];
            // Roughly half the reads hit the register being written
            rs = rng[5] ? rng[4:2] : rng[8:6];
            instr  <= {opRType, rs, rng[11:9], rng[14:12], rng[16:15]};
            pcInc  <= rng[31:16] ^ rng[15:0];
        end
        reportTest("register file");

        for (int i = 0; i < CtrlCycles - 2; i++) begin
            @(posedge clk);
            quiet();
            rng = xorshift(rng);
            instr <= {opList[i % 21], rng[10:0]};
            pcInc <= rng[26:11];
        end
        reportTest("control");

        for (int c = 0; c < 4; c++) begin
            for (int v = 0; v < 3; v++) begin
                @(posedge clk);
                quiet();
                rng = xorshift(rng);
                rs = rng[2:0];
                instr   <= {brList[c], rs, rng[10:3]};
                pcInc   <= rng[31:16];
                exFwdEn <= 1'b1;
                exRd    <= rs;
                // Zero, positive, negative
                exData  <= (v == 0) ? 16'h0000 :
                           (v == 1) ? {1'b0, rng[26:12]} : {1'b1, rng[26:12]};
            end
        end
        reportTest("branches");

        // EX and MEM both match, then MEM only, then the register file
        for (int k = 0; k < 3; k++) begin
            @(posedge clk);
            quiet();
            rng = xorshift(rng);
            instr    <= {opJr, 3'd3, rng[7:0]};
            exFwdEn  <= (k == 0);
            memFwdEn <= (k < 2);
            exRd     <= 3'd3;
            memRd    <= 3'd3;
            exData   <= rng[15:0];
            memData  <= rng[31:16];
        end
        reportTest("forwarding");

        for (int k = 0; k < 3; k++) begin
            @(posedge clk);
            quiet();
            rng = xorshift(rng);
            instr    <= (k == 0) ? {opJal, rng[10:0]} : {opJalr, 3'd7, rng[7:0]};
            pcInc    <= rng[31:16];
            exFwdEn  <= (k == 1);
            exLink   <= (k == 1);
            exRd     <= 3'd7;
            exPcInc  <= rng[15:0];
            exData   <= ~rng[15:0];
            memFwdEn <= (k == 2);
            memLink  <= (k == 2);
            memRd    <= 3'd7;
            memPcInc <= rng[26:11];
            memData  <= rng[20:5];
        end
        reportTest("link jumps");

        $display("tests run %0d, tests failed %0d, assertion failures %0d",
            testsRun, testsFailed, failsBefore);
        if (testsFailed == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+.
wisc_pkg.sv
regFileBypass.sv
immExtend.sv
branchUnit.sv
controlUnit.sv
decode.sv
decodeTop.sv
decode_assertions.sv
tb_decode.sv

//--- Bender.yml
package:
  name: wisc_decode

export_include_dirs:
  - .

sources:
  - files:
      - wisc_pkg.sv
      - regFileBypass.sv
      - immExtend.sv
      - branchUnit.sv
      - controlUnit.sv
      - decode.sv
      - decodeTop.sv
  - target: test
    files:
      - decode_assertions.sv
      - tb_decode.sv
